//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_core
FILELIST  = src.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- apb_arbiter.sv
// Fixed-priority APB arbiter merging fetch and load/store managers onto one external port
`timescale 1ns/1ps
`default_nettype none

module apb_arbiter (
  input  logic            clk_i,
  input  logic            rst_ni,
  apb_if.completer        fetch_bus_i,
  apb_if.completer        data_bus_i,
  output core_pkg::addr_t paddr_o,
  output logic            psel_o,
  output logic            penable_o,
  output logic            pwrite_o,
  output core_pkg::word_t pwdata_o,
  input  core_pkg::word_t prdata_i,
  input  logic            pready_i
);
  import core_pkg::*;

  // IDLE doubles as the external setup cycle
  localparam logic A_IDLE   = 1'b0;
  localparam logic A_ACCESS = 1'b1;

  logic state_q;
  logic owner_data_q;
  logic use_data;

  // Data side wins a tie on an idle bus
  assign use_data = (state_q == A_ACCESS) ? owner_data_q : data_bus_i.psel;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= A_IDLE;
      owner_data_q <= 1'b0;
    end else begin
      case (state_q)
        A_IDLE: begin
          if (fetch_bus_i.psel || data_bus_i.psel) begin
            state_q      <= A_ACCESS;
            owner_data_q <= use_data;
          end
        end
        A_ACCESS: if (pready_i) state_q <= A_IDLE;
        default:  state_q <= A_IDLE;
      endcase
    end
  end

  // ========================================
  // Forward the selected manager
  // ========================================
  always_comb begin
    if (use_data) begin
      paddr_o   = data_bus_i.paddr;
      psel_o    = data_bus_i.psel;
      penable_o = (state_q == A_ACCESS) && data_bus_i.penable;
      pwrite_o  = data_bus_i.pwrite;
      pwdata_o  = data_bus_i.pwdata;
    end else begin
      paddr_o   = fetch_bus_i.paddr;
      psel_o    = fetch_bus_i.psel;
      penable_o = (state_q == A_ACCESS) && fetch_bus_i.penable;
      pwrite_o  = fetch_bus_i.pwrite;
      pwdata_o  = fetch_bus_i.pwdata;
    end
  end

  // Losing manager sits in access with pready low
  assign data_bus_i.pready  = (state_q == A_ACCESS) && owner_data_q && pready_i;
  assign fetch_bus_i.pready = (state_q == A_ACCESS) && !owner_data_q && pready_i;
  assign data_bus_i.prdata  = owner_data_q ? prdata_i : '0;
  assign fetch_bus_i.prdata = owner_data_q ? '0 : prdata_i;

endmodule

`default_nettype wire

//--- apb_if.sv
// APB signal bundle between a core-side manager and the arbiter acting as completer
`timescale 1ns/1ps
`default_nettype none

interface apb_if;
  import core_pkg::*;

  addr_t paddr;
  logic  psel;
  logic  penable;
  logic  pwrite;
  word_t pwdata;
  word_t prdata;
  logic  pready;

  // Fetch and load/store units drive requests
  modport manager (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready
  );

  // Arbiter side, returns data and ready
  modport completer (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready
  );

endinterface

`default_nettype wire

//--- core_chk.sv
// Bound checker for APB phase rules and single-cycle trap pulses on the core top level
`timescale 1ns/1ps
`default_nettype none

module core_chk (
  input logic            clk_i,
  input logic            rst_ni,
  input core_pkg::addr_t paddr_i,
  input logic            psel_i,
  input logic            penable_i,
  input logic            pready_i,
  input logic            trap_i
);
  // ========================================
  // APB phases
  // ========================================
  // Setup lasts exactly one cycle
  setup_then_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (psel_i && !penable_i) |=> (psel_i && penable_i))
    else $error("APB setup not followed by access");

  // penable never without psel
  enable_needs_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_i |-> psel_i)
    else $error("penable high without psel");

  // Waiting access keeps its address
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (psel_i && penable_i && !pready_i) |=> (psel_i && penable_i && $stable(paddr_i)))
    else $error("APB address changed during wait");

  // Trap is a single pulse
  trap_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trap_i |=> !trap_i)
    else $error("trap_o longer than one cycle");

endmodule

bind rv_core_top core_chk u_chk (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .paddr_i  (paddr_o),
  .psel_i   (psel_o),
  .penable_i(penable_o),
  .pready_i (pready_i),
  .trap_i   (trap_o)
);

`default_nettype wire

//--- core_pkg.sv
// Shared widths, opcodes, trap causes and instruction views, imported by every core module
`default_nettype none

package core_pkg;

  // ========================================
  // Word and address widths
  // ========================================
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] word_t;

  // Major opcodes the core understands
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // RISC-V mcause numbers for the three kept traps
  typedef enum logic [3:0] {
    CAUSE_ILLEGAL_INSTR    = 4'd2,
    CAUSE_LOAD_MISALIGNED  = 4'd4,
    CAUSE_STORE_MISALIGNED = 4'd6
  } trap_cause_e;

  // ========================================
  // One instruction word, two field layouts
  // ========================================
  // R view also yields the I immediate as {funct7, rs2}
  // S view also yields the B immediate from imm_hi and imm_lo
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
    } r;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      opcode_e    opcode;
    } s;
  } instr_u;

  // A store to this address marks the end of a test program
  localparam addr_t HALT_ADDR = 32'h0000_0FFC;

endpackage

`default_nettype wire

//--- exec_unit.sv
// Execute unit with register file, decode, ALU, branches, load/store requests and traps
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
  parameter core_pkg::addr_t TRAP_VECTOR = '0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  inst_valid_i,
  input  core_pkg::instr_u      inst_i,
  input  core_pkg::addr_t       inst_pc_i,
  output logic                  inst_ready_o,
  output logic                  redirect_o,
  output core_pkg::addr_t       redirect_pc_o,
  output logic                  req_valid_o,
  output logic                  req_write_o,
  output core_pkg::addr_t       req_addr_o,
  output core_pkg::word_t       req_wdata_o,
  input  logic                  done_i,
  input  core_pkg::word_t       rdata_i,
  output logic                  trap_o,
  output core_pkg::trap_cause_e trap_cause_o
);
  import core_pkg::*;

  word_t rf_q [1:31];
  word_t rs1_val;
  word_t rs2_val;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t alu_b;
  word_t alu_res;
  word_t wb_data;
  addr_t mem_addr;
  logic  is_alu;
  logic  is_load;
  logic  is_store;
  logic  is_branch;
  logic  legal;
  logic  is_sub;
  logic  misaligned;
  logic  trap_any;
  logic  taken;
  logic  mem_busy;
  logic  accept;
  logic  rf_we;

  // x0 always reads as zero
  assign rs1_val = (inst_i.r.rs1 == 5'd0) ? '0 : rf_q[inst_i.r.rs1];
  assign rs2_val = (inst_i.r.rs2 == 5'd0) ? '0 : rf_q[inst_i.r.rs2];

  // Immediates from the two views of the same word
  assign imm_i = {{20{inst_i.r.funct7[6]}}, inst_i.r.funct7, inst_i.r.rs2};
  assign imm_s = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
  assign imm_b = {{19{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi[6], inst_i.s.imm_lo[0],
                  inst_i.s.imm_hi[5:0], inst_i.s.imm_lo[4:1], 1'b0};

  // ========================================
  // Decode
  // ========================================
  always_comb begin
    is_alu    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    legal     = 1'b0;
    case (inst_i.r.opcode)
      OPC_OP: begin
        is_alu = 1'b1;
        // SUB is the only funct7 variant kept
        legal  = ((inst_i.r.funct7 == 7'b0000000) &&
                  (inst_i.r.funct3 inside {3'b000, 3'b100, 3'b110, 3'b111})) ||
                 ((inst_i.r.funct7 == 7'b0100000) && (inst_i.r.funct3 == 3'b000));
      end
      OPC_OP_IMM: begin
        is_alu = 1'b1;
        legal  = (inst_i.r.funct3 == 3'b000);
      end
      OPC_LOAD: begin
        is_load = 1'b1;
        legal   = (inst_i.r.funct3 == 3'b010);
      end
      OPC_STORE: begin
        is_store = 1'b1;
        legal    = (inst_i.s.funct3 == 3'b010);
      end
      OPC_BRANCH: begin
        is_branch = 1'b1;
        legal     = (inst_i.s.funct3 inside {3'b000, 3'b001});
      end
      default: legal = 1'b0;
    endcase
  end

  // ALU, funct3 selects the operation, ADDI shares the adder
  assign is_sub = (inst_i.r.opcode == OPC_OP) && inst_i.r.funct7[5];
  assign alu_b  = (inst_i.r.opcode == OPC_OP) ? rs2_val : imm_i;

  always_comb begin
    case (inst_i.r.funct3)
      3'b100:  alu_res = rs1_val ^ alu_b;
      3'b110:  alu_res = rs1_val | alu_b;
      3'b111:  alu_res = rs1_val & alu_b;
      default: alu_res = is_sub ? (rs1_val - alu_b) : (rs1_val + alu_b);
    endcase
  end

  // Word access only, low address bits must be clear
  assign mem_addr   = rs1_val + (is_store ? imm_s : imm_i);
  assign misaligned = (is_load || is_store) && (mem_addr[1:0] != 2'b00);
  assign trap_any   = !legal || misaligned;

  always_comb begin
    if (!legal) begin
      trap_cause_o = CAUSE_ILLEGAL_INSTR;
    end else if (is_load) begin
      trap_cause_o = CAUSE_LOAD_MISALIGNED;
    end else begin
      trap_cause_o = CAUSE_STORE_MISALIGNED;
    end
  end

  // BEQ when funct3[0] clear, BNE when set
  assign taken = is_branch && ((rs1_val == rs2_val) ^ inst_i.s.funct3[0]);

  // ========================================
  // Handshake, bus request and redirect
  // ========================================
  // Busy while a load or store waits for the LSU
  assign mem_busy     = inst_valid_i && (is_load || is_store) && !trap_any && !done_i;
  assign inst_ready_o = !mem_busy;
  assign accept       = inst_valid_i && inst_ready_o;

  assign req_valid_o = inst_valid_i && (is_load || is_store) && !trap_any;
  assign req_write_o = is_store;
  assign req_addr_o  = mem_addr;
  assign req_wdata_o = rs2_val;

  assign redirect_o    = accept && (trap_any || taken);
  assign redirect_pc_o = trap_any ? TRAP_VECTOR : (inst_pc_i + imm_b);
  assign trap_o        = accept && trap_any;

  // Writeback, trapping instructions leave no result
  assign rf_we   = accept && !trap_any && (is_alu || is_load) && (inst_i.r.rd != 5'd0);
  assign wb_data = is_load ? rdata_i : alu_res;

  always_ff @(posedge clk_i) begin
    if (rst_ni && rf_we) begin
      rf_q[inst_i.r.rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

//--- fetch_unit.sv
// Instruction fetch with PC, APB word reads and a one-entry buffer feeding the execute unit
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter core_pkg::addr_t RESET_VECTOR = '0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  apb_if.manager           bus_o,
  output logic             inst_valid_o,
  output core_pkg::instr_u inst_o,
  output core_pkg::addr_t  inst_pc_o,
  input  logic             inst_ready_i,
  input  logic             redirect_i,
  input  core_pkg::addr_t  redirect_pc_i
);
  import core_pkg::*;

  localparam logic [1:0] F_IDLE   = 2'd0;
  localparam logic [1:0] F_SETUP  = 2'd1;
  localparam logic [1:0] F_ACCESS = 2'd2;

  logic [1:0] state_q;
  addr_t      pc_q;
  addr_t      rd_addr_q;
  addr_t      buf_pc_q;
  instr_u     buf_inst_q;
  logic       buf_valid_q;
  logic       stale_q;
  logic       take;
  logic       room;
  logic       start;
  logic       rd_done;

  // Buffer has room if empty or drained this cycle
  assign take    = buf_valid_q && inst_ready_i;
  assign room    = !buf_valid_q || take;
  assign start   = (state_q == F_IDLE) && room && !redirect_i;
  assign rd_done = (state_q == F_ACCESS) && bus_o.pready;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= F_IDLE;
      pc_q        <= RESET_VECTOR;
      buf_valid_q <= 1'b0;
      stale_q     <= 1'b0;
    end else begin
      case (state_q)
        F_IDLE:   if (start) state_q <= F_SETUP;
        F_SETUP:  state_q <= F_ACCESS;
        F_ACCESS: if (bus_o.pready) state_q <= F_IDLE;
        default:  state_q <= F_IDLE;
      endcase
      // Redirect overrides the sequential PC
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (start) begin
        pc_q <= pc_q + 32'd4;
      end
      // Stale or redirected words never reach the buffer
      if (rd_done && !stale_q && !redirect_i) begin
        buf_valid_q <= 1'b1;
      end else if (take || redirect_i) begin
        buf_valid_q <= 1'b0;
      end
      // Read already on the bus keeps running, result dropped
      if (rd_done) begin
        stale_q <= 1'b0;
      end else if (redirect_i && (state_q != F_IDLE)) begin
        stale_q <= 1'b1;
      end
    end
  end

  // Read address and fetched word
  always_ff @(posedge clk_i) begin
    if (start) begin
      rd_addr_q <= pc_q;
    end
    if (rd_done) begin
      buf_inst_q <= bus_o.prdata;
      buf_pc_q   <= rd_addr_q;
    end
  end

  assign bus_o.paddr   = rd_addr_q;
  assign bus_o.psel    = (state_q != F_IDLE);
  assign bus_o.penable = (state_q == F_ACCESS);
  assign bus_o.pwrite  = 1'b0;
  assign bus_o.pwdata  = '0;

  assign inst_valid_o = buf_valid_q;
  assign inst_o       = buf_inst_q;
  assign inst_pc_o    = buf_pc_q;

endmodule

`default_nettype wire

//--- lsu.sv
// Load/store unit carrying one execute-unit word request over APB until done
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  logic            clk_i,
  input  logic            rst_ni,
  apb_if.manager          bus_o,
  input  logic            req_valid_i,
  input  logic            req_write_i,
  input  core_pkg::addr_t req_addr_i,
  input  core_pkg::word_t req_wdata_i,
  output logic            done_o,
  output core_pkg::word_t rdata_o
);
  import core_pkg::*;

  localparam logic [1:0] L_IDLE   = 2'd0;
  localparam logic [1:0] L_SETUP  = 2'd1;
  localparam logic [1:0] L_ACCESS = 2'd2;

  logic [1:0] state_q;
  addr_t      addr_q;
  word_t      wdata_q;
  logic       write_q;

  // IDLE, then one setup cycle, then access until pready
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= L_IDLE;
    end else begin
      case (state_q)
        L_IDLE:   if (req_valid_i) state_q <= L_SETUP;
        L_SETUP:  state_q <= L_ACCESS;
        L_ACCESS: if (bus_o.pready) state_q <= L_IDLE;
        default:  state_q <= L_IDLE;
      endcase
    end
  end

  // Request captured once, stays stable for the whole transfer
  always_ff @(posedge clk_i) begin
    if ((state_q == L_IDLE) && req_valid_i) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      write_q <= req_write_i;
    end
  end

  assign bus_o.paddr   = addr_q;
  assign bus_o.psel    = (state_q != L_IDLE);
  assign bus_o.penable = (state_q == L_ACCESS);
  assign bus_o.pwrite  = write_q;
  assign bus_o.pwdata  = wdata_q;

  // Completion cycle, read data straight from the bus
  assign done_o  = (state_q == L_ACCESS) && bus_o.pready;
  assign rdata_o = bus_o.prdata;

endmodule

`default_nettype wire

//--- program_input.mem
# kind addr data (hex); kind 0 memory word, 1 expected store in order
# kind 2 expected trap cause in order, its addr column is unused
0 00000000 00500093
0 00000004 00300113
0 00000008 002081B3
0 0000000C 40208233
0 00000010 0020F2B3
0 00000014 0020E333
0 00000018 0020C3B3
0 0000001C 20000413
0 00000020 00342023
0 00000024 00442223
0 00000028 00542423
0 0000002C 00642623
0 00000030 00742823
0 00000034 10042483
0 00000038 00942A23
0 0000003C 00208463
0 00000040 00142C23
0 00000044 00209463
0 00000048 00042E23
0 0000004C 00108463
0 00000050 00042E23
0 00000054 00109463
0 00000058 00242E23
0 0000005C 00000513
0 00000060 00100593
0 00000064 00200613
0 00000068 00142123
0 00000080 00150513
0 00000084 00B50E63
0 00000088 00C50E63
0 0000008C 02A42023
0 00000090 7FE00693
0 00000094 00D686B3
0 00000098 00A6A023
0 0000009C 00000063
0 000000A0 00142703
0 000000A4 FFFFFFFF
0 00000300 CAFEF00D
1 00000200 00000008
1 00000204 00000002
1 00000208 00000001
1 0000020C 00000007
1 00000210 00000006
1 00000214 CAFEF00D
1 00000218 00000005
1 0000021C 00000003
1 00000220 00000003
1 00000FFC 00000003
2 00000000 00000006
2 00000000 00000004
2 00000000 00000002

//--- rv_core_top.sv
// Core top level joining fetch, execute, LSU and arbiter; a store to HALT_ADDR ends a test run
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter core_pkg::addr_t RESET_VECTOR = 32'h0000_0000,
  parameter core_pkg::addr_t TRAP_VECTOR  = 32'h0000_0080
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  output core_pkg::addr_t       paddr_o,
  output logic                  psel_o,
  output logic                  penable_o,
  output logic                  pwrite_o,
  output core_pkg::word_t       pwdata_o,
  input  core_pkg::word_t       prdata_i,
  input  logic                  pready_i,
  output logic                  trap_o,
  output core_pkg::trap_cause_e trap_cause_o
);
  import core_pkg::*;

  // Fetch to execute
  logic   inst_valid;
  instr_u inst;
  addr_t  inst_pc;
  logic   inst_ready;
  logic   redirect;
  addr_t  redirect_pc;

  // Execute to LSU
  logic   req_valid;
  logic   req_write;
  addr_t  req_addr;
  word_t  req_wdata;
  logic   done;
  word_t  rdata;

  apb_if fetch_bus ();
  apb_if data_bus ();

  fetch_unit #(
    .RESET_VECTOR(RESET_VECTOR)
  ) u_fetch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_o        (fetch_bus),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .inst_pc_o    (inst_pc),
    .inst_ready_i (inst_ready),
    .redirect_i   (redirect),
    .redirect_pc_i(redirect_pc)
  );

  exec_unit #(
    .TRAP_VECTOR(TRAP_VECTOR)
  ) u_exec (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .inst_valid_i (inst_valid),
    .inst_i       (inst),
    .inst_pc_i    (inst_pc),
    .inst_ready_o (inst_ready),
    .redirect_o   (redirect),
    .redirect_pc_o(redirect_pc),
    .req_valid_o  (req_valid),
    .req_write_o  (req_write),
    .req_addr_o   (req_addr),
    .req_wdata_o  (req_wdata),
    .done_i       (done),
    .rdata_i      (rdata),
    .trap_o       (trap_o),
    .trap_cause_o (trap_cause_o)
  );

  lsu u_lsu (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bus_o      (data_bus),
    .req_valid_i(req_valid),
    .req_write_i(req_write),
    .req_addr_i (req_addr),
    .req_wdata_i(req_wdata),
    .done_o     (done),
    .rdata_o    (rdata)
  );

  // Single external APB port shared by both managers
  apb_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .fetch_bus_i(fetch_bus),
    .data_bus_i (data_bus),
    .paddr_o    (paddr_o),
    .psel_o     (psel_o),
    .penable_o  (penable_o),
    .pwrite_o   (pwrite_o),
    .pwdata_o   (pwdata_o),
    .prdata_i   (prdata_i),
    .pready_i   (pready_i)
  );

endmodule

`default_nettype wire

//--- src.f
core_pkg.sv
apb_if.sv
fetch_unit.sv
lsu.sv
apb_arbiter.sv
exec_unit.sv
rv_core_top.sv
core_chk.sv
tb_core.sv

//--- tb_core.sv
// Testbench for rv_core_top; runs the program from program_input.mem and checks stores and traps
`timescale 1ns/1ps
`default_nettype none

module tb_core;
  import core_pkg::*;

  localparam addr_t RESET_VECTOR = 32'h0000_0000;
  localparam addr_t TRAP_VECTOR  = 32'h0000_0080;

  logic        clk;
  logic        rst_n;
  addr_t       paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        trap;
  trap_cause_e trap_cause;

  // Memory image and expected records
  word_t       mem [addr_t];
  addr_t       exp_st_addr [$];
  word_t       exp_st_data [$];
  logic [3:0]  exp_cause [$];

  int          prog_words;
  int          cycle_limit;
  int          cycles;
  int          st_idx;
  int          tr_idx;
  int          checks;
  int          errors;
  int          reset_errors;
  logic        load_ok;
  logic        first_seen;
  logic        halt_seen;
  logic        timed_out;
  logic [15:0] lfsr_q;
  logic [1:0]  wait_cnt;
  logic [3:0]  got_cause;
  int          fd;
  int          n;
  int          kind;
  logic [31:0] rec_addr;
  logic [31:0] rec_data;
  string       line;

  rv_core_top #(
    .RESET_VECTOR(RESET_VECTOR),
    .TRAP_VECTOR (TRAP_VECTOR)
  ) UUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .paddr_o     (paddr),
    .psel_o      (psel),
    .penable_o   (penable),
    .pwrite_o    (pwrite),
    .pwdata_o    (pwdata),
    .prdata_i    (prdata),
    .pready_i    (pready),
    .trap_o      (trap),
    .trap_cause_o(trap_cause)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // Galois LFSR stepped once per random bit
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // ========================================
  // APB memory model and bus monitor
  // ========================================
  always @(negedge clk) begin
    if (psel && !penable) begin
      // Setup phase picks 0 to 3 wait states
      lfsr_q      = lfsr_next(lfsr_q);
      wait_cnt[0] = lfsr_q[0];
      lfsr_q      = lfsr_next(lfsr_q);
      wait_cnt[1] = lfsr_q[0];
      pready      = 1'b0;
      if (rst_n && !first_seen) begin
        first_seen = 1'b1;
        checks++;
        if (pwrite) begin
          $display("mismatch at %0t: pwrite_o got %b expected %b", $time, pwrite, 1'b0);
          errors++;
          reset_errors++;
        end
        if (paddr != RESET_VECTOR) begin
          $display("mismatch at %0t: paddr_o got %h expected %h", $time, paddr,
                   RESET_VECTOR);
          errors++;
          reset_errors++;
        end
        $display("[reset] finished, %0d errors", reset_errors);
      end
    end else if (psel && penable) begin
      if (wait_cnt == 2'd0) begin
        pready = 1'b1;
        if (pwrite) begin
          mem[paddr] = pwdata;
          checks++;
          if (st_idx >= exp_st_addr.size()) begin
            $display("extra store at %0t to address %h", $time, paddr);
            errors++;
          end else begin
            if (paddr != exp_st_addr[st_idx]) begin
              $display("mismatch at %0t: paddr_o got %h expected %h", $time, paddr,
                       exp_st_addr[st_idx]);
              errors++;
            end
            if (pwdata != exp_st_data[st_idx]) begin
              $display("mismatch at %0t: pwdata_o got %h expected %h", $time, pwdata,
                       exp_st_data[st_idx]);
              errors++;
            end
          end
          st_idx++;
          if (paddr == HALT_ADDR) halt_seen = 1'b1;
        end else begin
          // Unmapped words read back as the inverted address
          prdata = mem.exists(paddr) ? mem[paddr] : ~paddr;
        end
      end else begin
        wait_cnt = wait_cnt - 2'd1;
        pready   = 1'b0;
      end
    end else begin
      pready = 1'b0;
    end

    // Trap pulses checked in order against kind 2 records
    if (rst_n && trap && !halt_seen) begin
      got_cause = trap_cause;
      checks++;
      if (tr_idx >= exp_cause.size()) begin
        $display("unexpected trap at %0t with cause %0d", $time, got_cause);
        errors++;
      end else if (got_cause != exp_cause[tr_idx]) begin
        $display("mismatch at %0t: trap_cause_o got %0d expected %0d", $time, got_cause,
                 exp_cause[tr_idx]);
        errors++;
      end
      tr_idx++;
    end
  end

  // Cycle counter for the timeout
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) timed_out = 1'b1;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    prdata       = '0;
    pready       = 1'b0;
    lfsr_q       = 16'd17;
    wait_cnt     = 2'd0;
    prog_words   = 0;
    cycle_limit  = 1000000;
    cycles       = 0;
    st_idx       = 0;
    tr_idx       = 0;
    checks       = 0;
    errors       = 0;
    reset_errors = 0;
    first_seen   = 1'b0;
    halt_seen    = 1'b0;
    timed_out    = 1'b0;
    load_ok      = 1'b0;

    // ========================================
    // Load records
    // ========================================
    fd = $fopen("program_input.mem", "r");
    if (fd == 0) begin
      $display("could not open program_input.mem");
      errors++;
    end else begin
      load_ok = 1'b1;
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          if ($sscanf(line, "%d %h %h", kind, rec_addr, rec_data) == 3) begin
            if (kind == 0) begin
              mem[rec_addr] = rec_data;
              prog_words++;
            end else if (kind == 1) begin
              exp_st_addr.push_back(rec_addr);
              exp_st_data.push_back(rec_data);
            end else begin
              exp_cause.push_back(rec_data[3:0]);
            end
          end
        end
      end
      $fclose(fd);
      cycle_limit = 40 * prog_words + 200;
    end

    if (load_ok) begin
      // Outputs stay quiet for both reset cycles
      repeat (2) begin
        @(negedge clk);
        checks++;
        if (psel || trap) begin
          $display("psel_o or trap_o high during reset at %0t", $time);
          errors++;
          reset_errors++;
        end
      end
      rst_n = 1'b1;

      wait (halt_seen || timed_out);
      @(negedge clk);

      checks++;
      if (st_idx < exp_st_addr.size()) begin
        $display("missing stores, %0d of %0d seen", st_idx, exp_st_addr.size());
        errors++;
      end
      $display("[stores] finished, %0d of %0d seen", st_idx, exp_st_addr.size());
      checks++;
      if (tr_idx != exp_cause.size()) begin
        $display("trap count wrong, %0d of %0d seen", tr_idx, exp_cause.size());
        errors++;
      end
      $display("[traps] finished, %0d of %0d seen", tr_idx, exp_cause.size());
      if (timed_out && !halt_seen) begin
        $display("timeout after %0d cycles without a halt store", cycles);
        errors++;
      end
      $display("[halt] finished after %0d cycles", cycles);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
